/* core_cfg.svh */
// Core configuration: word width, register count, data memory depth, link register
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path and instruction width
`define XLEN 16

// Architectural registers, r0 is an ordinary register
`define REG_COUNT 16

// Data memory words, addressed by the low bits of the ALU result
`define DMEM_DEPTH 256

// CALL writes its return address here, RET jumps to it
`define LINK_REG 15

`endif

/* isa_pkg.sv */
// Instruction set encodings: opcodes, ALU operations, branch conditions, flags
`default_nettype none

package isa_pkg;

	// Opcode in instruction bits 15:12
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,  // rd = rs + rt
		OP_SUB  = 4'd1,  // rd = rs - rt
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SLL  = 4'd5,  // Shift amount in bits 3:0
		OP_SRL  = 4'd6,
		OP_SRA  = 4'd7,
		OP_LW   = 4'd8,  // rd = mem[rs + sext(off4)]
		OP_SW   = 4'd9,  // mem[rs + sext(off4)] = rd
		OP_LHB  = 4'd10, // Replace high byte of rd
		OP_LLB  = 4'd11, // Replace low byte of rd
		OP_B    = 4'd12, // Cond in 11:9, offset in 8:0
		OP_CALL = 4'd13, // Target in 11:0
		OP_RET  = 4'd14,
		OP_HLT  = 4'd15
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		ALU_SRA = 3'd7
	} alu_op_e;

	// Branch condition in instruction bits 11:9
	typedef enum logic [2:0] {
		BR_NE     = 3'd0, // !Z
		BR_EQ     = 3'd1, // Z
		BR_GT     = 3'd2, // !Z && !N
		BR_LT     = 3'd3, // N
		BR_GE     = 3'd4, // Z || !N
		BR_LE     = 3'd5, // Z || N
		BR_OV     = 3'd6, // V
		BR_ALWAYS = 3'd7
	} br_cond_e;

	// Condition flags, written by ADD and SUB only
	typedef struct packed {
		logic z; // Result zero
		logic n; // Result negative
		logic v; // Signed overflow
	} flags_t;

endpackage

`default_nettype wire

/* pipe_pkg.sv */
// Pipeline payloads carried between fetch, decode, execute and writeback
`default_nettype none

`include "core_cfg.svh"

package pipe_pkg;

	import isa_pkg::*;

	typedef logic [`XLEN-1:0] word_t;                 // Data and instruction word
	typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t; // Register file index

	// Fetch to decode
	typedef struct packed {
		word_t pc;    // Address of this instruction
		word_t instr; // Raw instruction word
	} if_id_t;

	// Decode to execute
	typedef struct packed {
		word_t      pc;            // For branch target and link value
		logic       mem_to_reg;    // LW
		logic       reg_to_mem;    // SW
		alu_op_e    alu_op;
		logic       alu_src;       // Operand 2 is sign_ext, not rd_data_2
		logic [3:0] shift;         // Shift amount, or byte lane for LHB/LLB
		word_t      sign_ext;      // Memory or branch offset
		logic [7:0] load_half_imm; // Byte for LHB/LLB
		br_cond_e   branch_cond;
		logic [11:0] call_target;
		word_t      rd_data_1;     // Base, rs, old rd or link value
		word_t      rd_data_2;     // rt, or store data for SW
		logic       call;
		logic       ret;
		logic       branch;
		reg_idx_t   reg_rd;        // Destination register
		logic       reg_write;
		logic       halt;          // HLT
	} id_ex_t;

	// Execute to writeback
	typedef struct packed {
		word_t    alu_result; // Register value or memory address
		word_t    store_data;
		logic     mem_to_reg;
		logic     reg_to_mem;
		reg_idx_t reg_rd;
		logic     reg_write;
	} ex_wb_t;

	// Architectural register write as seen at the top
	typedef struct packed {
		logic     valid;
		reg_idx_t reg_addr;
		word_t    data;
	} wb_trace_t;

endpackage

`default_nettype wire

/* stage_reg.sv */
// Pipeline stage register: payload plus valid bit, cleared by reset or flush
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic // Stage payload struct
) (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire logic     flush,     // Kill the instruction being captured
	input  wire logic     in_valid,
	input  wire payload_t in_data,
	output logic          out_valid,
	output payload_t      out_data
);

	// Valid is control state
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Payload follows the input every cycle, qualified by out_valid downstream
	always_ff @(posedge clk) begin
		out_data <= in_data;
	end

endmodule

`default_nettype wire

/* reg_file.sv */
// Register file: two combinational read ports, one write port, write-through
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module reg_file (
	input  wire logic                           clk,
	input  wire logic                           rst_n,
	input  wire logic [$clog2(`REG_COUNT)-1:0] rd_addr_1,
	input  wire logic [$clog2(`REG_COUNT)-1:0] rd_addr_2,
	output logic [`XLEN-1:0]                    rd_data_1,
	output logic [`XLEN-1:0]                    rd_data_2,
	input  wire logic                           wr_en,
	input  wire logic [$clog2(`REG_COUNT)-1:0] wr_addr,
	input  wire logic [`XLEN-1:0]               wr_data
);

	logic [`XLEN-1:0] regs [`REG_COUNT]; // Architectural registers

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0; // All registers start at zero
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Bypass the write of this cycle so decode sees it immediately
	always_comb begin
		if (wr_en && (wr_addr == rd_addr_1)) begin
			rd_data_1 = wr_data;
		end else begin
			rd_data_1 = regs[rd_addr_1];
		end
		if (wr_en && (wr_addr == rd_addr_2)) begin
			rd_data_2 = wr_data;
		end else begin
			rd_data_2 = regs[rd_addr_2];
		end
	end

endmodule

`default_nettype wire

/* decode_unit.sv */
// Decode: splits the instruction into control fields, reads operands, extends offsets
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module decode_unit
	import isa_pkg::*, pipe_pkg::*;
(
	input  wire if_id_t   in_data,
	input  wire logic     in_valid,
	output reg_idx_t      rd_addr_1,
	output reg_idx_t      rd_addr_2,
	input  wire word_t    rd_data_1,
	input  wire word_t    rd_data_2,
	output id_ex_t        out_data,
	output logic          out_valid
);

	word_t   instr;
	opcode_e op;
	logic    is_rtype; // ADD through SRA

	assign instr    = in_data.instr;
	assign op       = opcode_e'(instr[15:12]);
	assign is_rtype = (instr[15] == 1'b0); // Opcodes 0 to 7

	// Port 1 reads rd for SW, LHB, LLB and B, the link register for RET
	always_comb begin
		rd_addr_1 = instr[7:4]; // rs
		rd_addr_2 = instr[3:0]; // rt
		case (op)
			OP_SW: begin
				rd_addr_1 = instr[11:8]; // Store data
				rd_addr_2 = instr[7:4];  // Base
			end
			OP_LHB, OP_LLB, OP_B: rd_addr_1 = instr[11:8];
			OP_RET:               rd_addr_1 = reg_idx_t'(`LINK_REG);
			default: ;
		endcase
	end

	always_comb begin
		out_data               = '0;
		out_data.pc            = in_data.pc;
		out_data.mem_to_reg    = (op == OP_LW);
		out_data.reg_to_mem    = (op == OP_SW);
		out_data.alu_op        = is_rtype ? alu_op_e'(instr[14:12]) : ALU_ADD; // Same order
		out_data.alu_src       = !is_rtype; // Only R-type takes rt
		out_data.shift         = instr[3:0];
		out_data.load_half_imm = instr[7:0];
		out_data.branch_cond   = br_cond_e'(instr[11:9]);
		out_data.call_target   = instr[11:0];
		out_data.call          = (op == OP_CALL);
		out_data.ret           = (op == OP_RET);
		out_data.branch        = (op == OP_B);
		out_data.halt          = (op == OP_HLT);
		out_data.reg_rd        = (op == OP_CALL) ? reg_idx_t'(`LINK_REG) : instr[11:8];
		out_data.reg_write     = is_rtype || (op == OP_LW) || (op == OP_LHB) ||
			(op == OP_LLB) || (op == OP_CALL);
		// Base goes to operand 1, store data to operand 2
		out_data.rd_data_1     = (op == OP_SW) ? rd_data_2 : rd_data_1;
		out_data.rd_data_2     = (op == OP_SW) ? rd_data_1 : rd_data_2;
		case (op)
			OP_LW, OP_SW: out_data.sign_ext = {{(`XLEN-4){instr[3]}}, instr[3:0]};
			OP_B:         out_data.sign_ext = {{(`XLEN-9){instr[8]}}, instr[8:0]};
			OP_LHB:       out_data.shift    = 4'd8; // High byte lane
			OP_LLB:       out_data.shift    = 4'd0; // Low byte lane
			default: ;
		endcase
	end

	assign out_valid = in_valid; // No stall, no kill here

endmodule

`default_nettype wire

/* exec_unit.sv */
// Execute: ALU, condition flags, branch/call/return resolution and PC redirect
`timescale 1ns/1ps
`default_nettype none

module exec_unit
	import isa_pkg::*, pipe_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire id_ex_t in_data,
	input  wire logic   in_valid,
	output ex_wb_t      out_data,
	output logic        out_valid,
	output logic        redirect,    // Flush and load PC
	output word_t       redirect_pc,
	output logic        halt_seen
);

	localparam int MSB = $bits(word_t) - 1;

	word_t  op_a, op_b;  // ALU operands
	word_t  alu_out;
	word_t  half_merged; // LHB/LLB result
	word_t  link;        // pc + 1
	logic   is_half;
	logic   set_flags;
	logic   taken;
	flags_t flags, flags_next;

	assign op_a = in_data.rd_data_1;
	assign op_b = in_data.alu_src ? in_data.sign_ext : in_data.rd_data_2;
	assign link = in_data.pc + word_t'(1);

	always_comb begin
		case (in_data.alu_op)
			ALU_ADD: alu_out = op_a + op_b;
			ALU_SUB: alu_out = op_a - op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_OR:  alu_out = op_a | op_b;
			ALU_XOR: alu_out = op_a ^ op_b;
			ALU_SLL: alu_out = op_a << in_data.shift;
			ALU_SRL: alu_out = op_a >> in_data.shift;
			default: alu_out = word_t'($signed(op_a) >>> in_data.shift); // SRA
		endcase
	end

	// Byte merge, shift selects the lane being replaced
	assign is_half = in_data.reg_write && in_data.alu_src && !in_data.mem_to_reg &&
		!in_data.call;
	assign half_merged = (op_a & ~(word_t'(8'hFF) << in_data.shift)) |
		(word_t'(in_data.load_half_imm) << in_data.shift);

	// Only R-type ADD and SUB touch the flags
	assign set_flags = !in_data.alu_src &&
		((in_data.alu_op == ALU_ADD) || (in_data.alu_op == ALU_SUB));
	always_comb begin
		flags_next.z = (alu_out == '0);
		flags_next.n = alu_out[MSB];
		if (in_data.alu_op == ALU_SUB) begin
			flags_next.v = (op_a[MSB] != op_b[MSB]) && (alu_out[MSB] != op_a[MSB]);
		end else begin
			flags_next.v = (op_a[MSB] == op_b[MSB]) && (alu_out[MSB] != op_a[MSB]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (in_valid && set_flags) begin
			flags <= flags_next;
		end
	end

	always_comb begin
		case (in_data.branch_cond)
			BR_NE:   taken = !flags.z;
			BR_EQ:   taken = flags.z;
			BR_GT:   taken = !flags.z && !flags.n;
			BR_LT:   taken = flags.n;
			BR_GE:   taken = flags.z || !flags.n;
			BR_LE:   taken = flags.z || flags.n;
			BR_OV:   taken = flags.v;
			default: taken = 1'b1; // Always
		endcase
	end

	assign redirect  = in_valid && (in_data.call || in_data.ret || (in_data.branch && taken));
	assign redirect_pc = in_data.ret ? in_data.rd_data_1 :
		in_data.call ? word_t'(in_data.call_target) : link + in_data.sign_ext;
	assign halt_seen = in_valid && in_data.halt;

	assign out_data.alu_result = in_data.call ? link : (is_half ? half_merged : alu_out);
	assign out_data.store_data = in_data.rd_data_2;
	assign out_data.mem_to_reg = in_data.mem_to_reg;
	assign out_data.reg_to_mem = in_data.reg_to_mem;
	assign out_data.reg_rd     = in_data.reg_rd;
	assign out_data.reg_write  = in_data.reg_write;
	assign out_valid           = in_valid;

endmodule

`default_nettype wire

/* wb_unit.sv */
// Writeback: data memory access and register write selection with trace output
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module wb_unit
	import pipe_pkg::*;
(
	input  wire logic   clk,
	input  wire ex_wb_t in_data,
	input  wire logic   in_valid,
	output logic        wr_en,
	output reg_idx_t    wr_addr,
	output word_t       wr_data,
	output wb_trace_t   wb_trace
);

	localparam int AW = $clog2(`DMEM_DEPTH); // Word address bits

	word_t           dmem [`DMEM_DEPTH]; // Data memory
	logic [AW-1:0]   mem_addr;
	word_t           load_data;

	assign mem_addr  = in_data.alu_result[AW-1:0]; // Upper address bits ignored
	assign load_data = dmem[mem_addr];             // Asynchronous read

	always_ff @(posedge clk) begin
		if (in_valid && in_data.reg_to_mem) begin
			dmem[mem_addr] <= in_data.store_data;
		end
	end

	// Register write port
	assign wr_en   = in_valid && in_data.reg_write;
	assign wr_addr = in_data.reg_rd;
	assign wr_data = in_data.mem_to_reg ? load_data : in_data.alu_result;

	// Same write, seen from outside
	assign wb_trace.valid    = wr_en;
	assign wb_trace.reg_addr = wr_addr;
	assign wb_trace.data     = wr_data;

endmodule

`default_nettype wire

/* core_top.sv */
// Core top: PC, fetch port, halt state and four-stage pipeline wiring
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module core_top
	import pipe_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	output word_t      imem_addr,
	input  wire word_t imem_data, // Combinational reply to imem_addr
	output wb_trace_t  wb_trace,
	output logic       halted
);

	word_t    pc;
	if_id_t   fetch_data;
	if_id_t   if_id_data;
	logic     if_id_valid;
	id_ex_t   dec_data, id_ex_data;
	logic     dec_valid, id_ex_valid;
	ex_wb_t   ex_data, ex_wb_data;
	logic     ex_valid, ex_wb_valid;
	logic     redirect;
	word_t    redirect_pc;
	logic     halt_seen;
	logic     kill;          // Drop the two younger instructions
	reg_idx_t rf_rd_addr_1, rf_rd_addr_2;
	word_t    rf_rd_data_1, rf_rd_data_2;
	logic     rf_wr_en;
	reg_idx_t rf_wr_addr;
	word_t    rf_wr_data;

	assign kill = redirect || halt_seen;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc     <= '0;
			halted <= 1'b0;
		end else begin
			if (redirect) begin
				pc <= redirect_pc;
			end else if (!halted && !halt_seen) begin
				pc <= pc + word_t'(1); // Sequential fetch
			end
			if (halt_seen) begin
				halted <= 1'b1; // Sticky until reset
			end
		end
	end

	assign imem_addr        = pc;
	assign fetch_data.pc    = pc;
	assign fetch_data.instr = imem_data;

	stage_reg #(.payload_t(if_id_t)) if_id_reg (
		.clk(clk), .rst_n(rst_n), .flush(kill),
		.in_valid(!halted), .in_data(fetch_data),
		.out_valid(if_id_valid), .out_data(if_id_data)
	);

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n),
		.rd_addr_1(rf_rd_addr_1), .rd_addr_2(rf_rd_addr_2),
		.rd_data_1(rf_rd_data_1), .rd_data_2(rf_rd_data_2),
		.wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data)
	);

	decode_unit u_decode (
		.in_data(if_id_data), .in_valid(if_id_valid),
		.rd_addr_1(rf_rd_addr_1), .rd_addr_2(rf_rd_addr_2),
		.rd_data_1(rf_rd_data_1), .rd_data_2(rf_rd_data_2),
		.out_data(dec_data), .out_valid(dec_valid)
	);

	stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
		.clk(clk), .rst_n(rst_n), .flush(kill),
		.in_valid(dec_valid), .in_data(dec_data),
		.out_valid(id_ex_valid), .out_data(id_ex_data)
	);

	exec_unit u_exec (
		.clk(clk), .rst_n(rst_n),
		.in_data(id_ex_data), .in_valid(id_ex_valid),
		.out_data(ex_data), .out_valid(ex_valid),
		.redirect(redirect), .redirect_pc(redirect_pc), .halt_seen(halt_seen)
	);

	stage_reg #(.payload_t(ex_wb_t)) ex_wb_reg (
		.clk(clk), .rst_n(rst_n), .flush(1'b0), // Redirecting instruction retires
		.in_valid(ex_valid), .in_data(ex_data),
		.out_valid(ex_wb_valid), .out_data(ex_wb_data)
	);

	wb_unit u_wb (
		.clk(clk), .in_data(ex_wb_data), .in_valid(ex_wb_valid),
		.wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data),
		.wb_trace(wb_trace)
	);

endmodule

`default_nettype wire

/* tb_core.sv */
// Core testbench: program image, sequential reference model and trace assertions
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module tb_core
	import isa_pkg::*, pipe_pkg::*;
();

	localparam int    IMEM_DEPTH   = 256;
	localparam int    HALT_TIMEOUT = 1000; // Cycles
	localparam int    MODEL_STEPS  = 2000;
	localparam word_t PAD          = {OP_OR, 4'd14, 4'd14, 4'd14}; // r14 = r14, spacing filler
	localparam word_t HLT_WORD     = {OP_HLT, 12'h000};
	localparam word_t RET_WORD     = {OP_RET, 12'h000};

	logic      clk;
	logic      rst_n;
	word_t     imem_addr;
	word_t     imem_data;
	wb_trace_t wb_trace;
	logic      halted;

	word_t     imem [IMEM_DEPTH];     // Program image
	int        prog_len;              // Next free slot
	int        seed = 80;
	wb_trace_t exp_q [$];             // Expected register writes, in order
	wb_trace_t exp_write;
	int        trace_count;
	word_t     m_regs [`REG_COUNT];   // Reference model state
	word_t     m_mem [`DMEM_DEPTH];   // Persists over resets like the DUT memory
	logic      m_z, m_n, m_v;
	word_t     m_pc;

	core_top uut (
		.clk(clk), .rst_n(rst_n),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.wb_trace(wb_trace), .halted(halted)
	);

	// Outside the image every word is a HLT
	assign imem_data = (imem_addr < IMEM_DEPTH) ? imem[imem_addr[7:0]] :
		{4'hF, imem_addr[11:0]};

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// Every architectural write must match the head of the model queue
	always @(posedge clk) begin
		if (rst_n && wb_trace.valid) begin
			assert (exp_q.size() != 0) begin
				exp_write = exp_q.pop_front();
				assert (wb_trace == exp_write) begin
					trace_count++;
				end else begin
					abort_run($sformatf("mismatch at %0t: core wrote r%0d = %h, expected r%0d = %h",
						$time, wb_trace.reg_addr, wb_trace.data, exp_write.reg_addr, exp_write.data));
				end
			end else begin
				abort_run($sformatf("core wrote r%0d = %h at %0t but the model expects no write",
					wb_trace.reg_addr, wb_trace.data, $time));
			end
		end
	end

	function automatic word_t fetch_word(input word_t addr);
		if (addr < IMEM_DEPTH) begin
			return imem[addr[7:0]];
		end
		return {4'hF, addr[11:0]};
	endfunction

	function automatic word_t pack_fields(input opcode_e op, input logic [3:0] f2,
		input logic [3:0] f1, input logic [3:0] f0);
		return {op, f2, f1, f0};
	endfunction

	function automatic word_t branch_word(input br_cond_e cond, input logic [8:0] off);
		return {OP_B, cond, off};
	endfunction

	task automatic emit(input word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic fill_imem();
		int i;
		for (i = 0; i < IMEM_DEPTH; i++) begin
			imem[i] = {4'hF, 4'h0, i[7:0]}; // HLT tagged with its address
		end
		prog_len = 0;
	endtask

	// LLB then LHB, padded so the value is usable by the next instruction
	task automatic load_const(input logic [3:0] rd, input word_t val);
		emit(pack_fields(OP_LLB, rd, val[7:4], val[3:0]));
		emit(PAD);
		emit(pack_fields(OP_LHB, rd, val[15:12], val[11:8]));
		emit(PAD);
	endtask

	task automatic write_reg(input logic [3:0] rd, input word_t val);
		wb_trace_t w;
		w.valid    = 1'b1;
		w.reg_addr = rd;
		w.data     = val;
		m_regs[rd] = val;
		exp_q.push_back(w);
	endtask

	// Sequential ISA model, one instruction at a time
	task automatic run_model();
		word_t      instr, a, b, r, addr, next_pc;
		logic [3:0] rd;
		int         steps, wide, i;
		logic       done, take;
		for (i = 0; i < `REG_COUNT; i++) begin
			m_regs[i] = '0;
		end
		{m_z, m_n, m_v} = 3'b000;
		m_pc  = '0;
		done  = 1'b0;
		steps = 0;
		while (!done) begin
			if (steps == MODEL_STEPS) begin
				abort_run("reference model never reached a HLT");
			end
			steps++;
			instr   = fetch_word(m_pc);
			rd      = instr[11:8];
			a       = m_regs[instr[7:4]];
			b       = m_regs[instr[3:0]];
			next_pc = m_pc + 16'd1;
			case (opcode_e'(instr[15:12]))
				OP_ADD, OP_SUB: begin
					if (instr[15:12] == OP_SUB) begin
						wide = int'($signed(a)) - int'($signed(b));
					end else begin
						wide = int'($signed(a)) + int'($signed(b));
					end
					r   = wide[15:0];
					m_z = (r == '0);
					m_n = r[15];
					m_v = (wide > 32767) || (wide < -32768); // Out of 16-bit signed range
					write_reg(rd, r);
				end
				OP_AND: write_reg(rd, a & b);
				OP_OR:  write_reg(rd, a | b);
				OP_XOR: write_reg(rd, a ^ b);
				OP_SLL: write_reg(rd, a << instr[3:0]);
				OP_SRL: write_reg(rd, a >> instr[3:0]);
				OP_SRA: begin
					wide = int'($signed(a)) >>> instr[3:0];
					write_reg(rd, wide[15:0]);
				end
				OP_LW, OP_SW: begin
					addr = a + {{12{instr[3]}}, instr[3:0]};
					if (instr[15:12] == OP_SW) begin
						m_mem[addr[7:0]] = m_regs[rd];
					end else begin
						write_reg(rd, m_mem[addr[7:0]]);
					end
				end
				OP_LHB: write_reg(rd, {instr[7:0], m_regs[rd][7:0]});
				OP_LLB: write_reg(rd, {m_regs[rd][15:8], instr[7:0]});
				OP_B: begin
					case (br_cond_e'(instr[11:9]))
						BR_NE:   take = !m_z;
						BR_EQ:   take = m_z;
						BR_GT:   take = !m_z && !m_n;
						BR_LT:   take = m_n;
						BR_GE:   take = m_z || !m_n;
						BR_LE:   take = m_z || m_n;
						BR_OV:   take = m_v;
						default: take = 1'b1;
					endcase
					if (take) begin
						next_pc = m_pc + 16'd1 + {{7{instr[8]}}, instr[8:0]};
					end
				end
				OP_CALL: begin
					write_reg(4'(`LINK_REG), m_pc + 16'd1);
					next_pc = {4'h0, instr[11:0]};
				end
				OP_RET:  next_pc = m_regs[`LINK_REG];
				default: done = 1'b1; // HLT
			endcase
			m_pc = next_pc;
		end
	endtask

	task automatic start_program();
		@(negedge clk);
		rst_n = 1'b0;
		fill_imem();
	endtask

	task automatic run_program(input string name);
		int    cyc;
		word_t stop_addr;
		repeat (4) @(negedge clk); // Four rising edges in reset
		assert (imem_addr == '0 && !halted && !wb_trace.valid)
		else abort_run($sformatf("%s: fetch address, halted or trace not cleared by reset", name));
		run_model();
		rst_n = 1'b1;
		cyc   = 0;
		while (!halted && cyc < HALT_TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		assert (halted)
		else abort_run($sformatf("%s: the core never halted", name));
		stop_addr = imem_addr;
		repeat (8) begin
			@(negedge clk);
			assert (halted && imem_addr == stop_addr)
			else abort_run($sformatf("%s: halted dropped or fetch moved on after HLT", name));
		end
		assert (exp_q.size() == 0)
		else abort_run($sformatf("%s: core made fewer register writes than the model", name));
		$display("%s program done, %0d register writes so far", name, trace_count);
	endtask

	// All eight ALU ops on two random operands, shifts by a random amount
	task automatic alu_program();
		word_t a, b;
		int    i;
		a = word_t'($random(seed));
		b = word_t'($random(seed));
		load_const(4'd1, a);
		load_const(4'd2, b);
		for (i = 0; i < 8; i++) begin
			if (i >= 5) begin
				emit(pack_fields(opcode_e'(i), 4'(3 + i), 4'd1, 4'($random(seed))));
			end else begin
				emit(pack_fields(opcode_e'(i), 4'(3 + i), 4'd1, 4'd2));
			end
		end
		emit(HLT_WORD);
	endtask

	// Store then load back, plus byte merges on a non-zero register
	task automatic memory_program();
		logic [3:0] off_a, off_b;
		logic [7:0] nb;
		off_a = 4'($random(seed));
		off_b = 4'($random(seed));
		nb    = 8'($random(seed));
		load_const(4'd1, word_t'($random(seed)) & 16'h00FF); // Base
		load_const(4'd2, word_t'($random(seed)));
		load_const(4'd5, word_t'($random(seed)));
		emit(pack_fields(OP_SW, 4'd2, 4'd1, off_a));
		emit(pack_fields(OP_LW, 4'd3, 4'd1, off_a));
		emit(pack_fields(OP_SW, 4'd5, 4'd1, off_b));
		emit(pack_fields(OP_LW, 4'd4, 4'd1, off_b));
		emit(pack_fields(OP_LLB, 4'd5, nb[7:4], nb[3:0])); // Keeps the random high byte
		emit(PAD);
		emit(pack_fields(OP_LHB, 4'd5, nb[3:0], nb[7:4]));
		emit(HLT_WORD);
	endtask

	// Four flag states times eight conditions, each branch over two markers
	task automatic branch_program();
		word_t a, b, big;
		int    s, c;
		a   = (word_t'($random(seed)) & 16'h3FFF) | 16'h0001;
		b   = a + word_t'(($random(seed) & 32'hFF) + 1);
		big = 16'h7000 | (word_t'($random(seed)) & 16'h0FFF); // Doubling overflows
		load_const(4'd1, a);
		load_const(4'd2, b);
		load_const(4'd4, big);
		for (s = 0; s < 4; s++) begin
			for (c = 0; c < 8; c++) begin
				case (s)
					0:       emit(pack_fields(OP_SUB, 4'd3, 4'd1, 4'd1)); // Zero
					1:       emit(pack_fields(OP_SUB, 4'd3, 4'd2, 4'd1)); // Positive
					2:       emit(pack_fields(OP_SUB, 4'd3, 4'd1, 4'd2)); // Negative
					default: emit(pack_fields(OP_ADD, 4'd3, 4'd4, 4'd4)); // Overflow
				endcase
				emit(branch_word(br_cond_e'(c), 9'd2));
				emit(pack_fields(OP_LLB, 4'd12, 4'(s), 4'(c))); // Skipped if taken
				emit(pack_fields(OP_LLB, 4'd13, 4'(s), 4'(c)));
			end
		end
		emit(HLT_WORD);
	endtask

	// Two calls to one subroutine that branches forward and back before RET
	task automatic call_program();
		emit({OP_CALL, 12'h040});
		emit(pack_fields(OP_LLB, 4'd9, 4'h1, 4'h1));
		emit({OP_CALL, 12'h040});
		emit(pack_fields(OP_LLB, 4'd10, 4'h3, 4'h3));
		emit(HLT_WORD);
		prog_len = 'h40;
		emit(branch_word(BR_ALWAYS, 9'd2));
		emit(pack_fields(OP_LLB, 4'd7, 4'hE, 4'hE)); // Never executed
		emit(RET_WORD);
		emit(pack_fields(OP_LLB, 4'd8, 4'h2, 4'h2));
		emit(branch_word(BR_ALWAYS, 9'h1FD)); // Back to the RET
		emit(HLT_WORD);
	endtask

	initial begin
		rst_n       = 1'b0;
		trace_count = 0;
		fill_imem();
		repeat (3) begin
			start_program();
			alu_program();
			run_program("alu");
		end
		start_program();
		memory_program();
		run_program("memory");
		start_program();
		branch_program();
		run_program("branch");
		start_program();
		call_program();
		run_program("call");
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
stage_reg.sv
reg_file.sv
decode_unit.sv
exec_unit.sv
wb_unit.sv
core_top.sv
tb_core.sv

/* Bender.yml */
package:
  name: pipe_core

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - stage_reg.sv
      - reg_file.sv
      - decode_unit.sv
      - exec_unit.sv
      - wb_unit.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core.sv
